//--- pce_params.svh
// shared parameters for the bridge side of the console core
// region codes, loader timing, FIFO depth and reset hold length
`ifndef PCE_PARAMS_SVH
`define PCE_PARAMS_SVH

// bridge address regions
`define PCE_REGION_CORE_REG 8'h00
`define PCE_LOADER_NIBBLE 4'h1

// loader timing and buffering
`define PCE_LOADER_GAP 3
`define PCE_LOADER_DEPTH 4

// core reset hold, shortened for simulation
`define PCE_RESET_HOLD 64

// bus widths
`define PCE_BRIDGE_W 32
`define PCE_MEM_ADDR_W 24
`define PCE_MEM_DATA_W 16

`endif

//--- pce_bridge_pkg.sv
// bridge-facing types
// address regions and settings register offsets
package pce_bridge_pkg;

  // region of a bridge address, taken from its top bits
  typedef enum logic [1:0] {
    REGION_CORE_REG = 2'd0,
    REGION_LOADER   = 2'd1,
    REGION_NONE     = 2'd2
  } bridge_region_t;

  // offsets inside the settings region, low 16 address bits
  typedef enum logic [15:0] {
    OFS_CORE_RESET    = 16'h0050,
    // input options
    OFS_TURBO_TAP     = 16'h0100,
    OFS_BUTTON6       = 16'h0104,
    OFS_B1_TURBO      = 16'h0108,
    OFS_B2_TURBO      = 16'h010C,
    // video options
    OFS_OVERSCAN      = 16'h0200,
    OFS_EXTRA_SPRITES = 16'h0204,
    OFS_RAW_RGB       = 16'h0208,
    // audio options
    OFS_MASTER_BOOST  = 16'h0300,
    OFS_ADPCM_BOOST   = 16'h0304,
    OFS_CD_BOOST      = 16'h0308
  } settings_offset_t;

endpackage

//--- pce_core_pkg.sv
// core-facing types
// settings bundle and 16-bit memory write
`include "pce_params.svh"

package pce_core_pkg;

  // settings as seen by the console core
  typedef struct packed {
    logic       turbo_tap_enable;
    logic       button6_enable;
    logic [1:0] button1_turbo_speed;
    logic [1:0] button2_turbo_speed;
    logic       overscan_enable;
    logic       extra_sprites_enable;
    logic       raw_rgb_enable;
    logic [1:0] master_audio_boost;
    logic       adpcm_audio_boost;
    logic       cd_audio_boost;
  } core_settings_t;

  // one half-word write into ROM memory
  typedef struct packed {
    logic                        en;
    // byte address
    logic [`PCE_MEM_ADDR_W-1:0] addr;
    logic [`PCE_MEM_DATA_W-1:0] data;
  } mem_write_t;

endpackage

//--- bridge_region_decode.sv
// bridge region decoder
// classifies the top address bits, turns bridge writes into
// per-region strobes and muxes read data back to the host
`timescale 1ns/1ps
`include "pce_params.svh"

module bridge_region_decode
  import pce_bridge_pkg::*;
(
  input  logic [`PCE_BRIDGE_W-1:0] bridge_addr,
  input  logic                     bridge_wr,
  input  logic [`PCE_BRIDGE_W-1:0] settings_rd_data,
  output logic                     settings_wr,
  output logic                     loader_wr,
  output logic [`PCE_BRIDGE_W-1:0] bridge_rd_data
);

  bridge_region_t region;
  logic           core_reg_hit;
  logic           loader_hit;

  ////////////////////////////////////////////////////////////
  // region classification

  // each region code is matched on its own
  assign core_reg_hit = (bridge_addr[31:24] == `PCE_REGION_CORE_REG);
  assign loader_hit   = (bridge_addr[31:28] == `PCE_LOADER_NIBBLE);

  always_comb begin
    if (core_reg_hit) begin
      region = REGION_CORE_REG;
    end else if (loader_hit) begin
      region = REGION_LOADER;
    end else begin
      region = REGION_NONE;
    end
  end

  // write strobes follow bridge_wr directly
  assign settings_wr = bridge_wr && core_reg_hit;
  assign loader_wr   = bridge_wr && loader_hit;

  ////////////////////////////////////////////////////////////
  // read mux, zero outside the settings block

  always_comb begin
    case (region)
      REGION_CORE_REG: bridge_rd_data = settings_rd_data;
      default:         bridge_rd_data = '0;
    endcase
  end

  // a write lands in one block only
  always_comb begin
    assert (!(settings_wr && loader_wr))
      else $error("settings and loader strobes high together");
  end

endmodule

//--- core_settings_regs.sv
// core settings register block
// holds the option fields, reads them back right-justified and
// runs the host-triggered core reset hold
`timescale 1ns/1ps
`include "pce_params.svh"

module core_settings_regs
  import pce_bridge_pkg::*;
  import pce_core_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     reset,
  input  logic                     settings_wr,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_addr,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_wr_data,
  output core_settings_t           settings,
  output logic                     core_reset,
  output logic [`PCE_BRIDGE_W-1:0] settings_rd_data
);

  localparam int HOLD_W = $clog2(`PCE_RESET_HOLD + 1);

  settings_offset_t   offset;
  logic [HOLD_W-1:0]  hold_cnt;
  logic               reset_wr;

  // only the offset is decoded here, the region is already known
  assign offset   = settings_offset_t'(bridge_addr[15:0]);
  assign reset_wr = settings_wr && (offset == OFS_CORE_RESET);

  ////////////////////////////////////////////////////////////
  // field updates

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      settings <= '0;
    end else if (settings_wr) begin
      case (offset)
        OFS_TURBO_TAP:     settings.turbo_tap_enable     <= bridge_wr_data[0];
        OFS_BUTTON6:       settings.button6_enable       <= bridge_wr_data[0];
        OFS_B1_TURBO:      settings.button1_turbo_speed  <= bridge_wr_data[1:0];
        OFS_B2_TURBO:      settings.button2_turbo_speed  <= bridge_wr_data[1:0];
        OFS_OVERSCAN:      settings.overscan_enable      <= bridge_wr_data[0];
        OFS_EXTRA_SPRITES: settings.extra_sprites_enable <= bridge_wr_data[0];
        OFS_RAW_RGB:       settings.raw_rgb_enable       <= bridge_wr_data[0];
        OFS_MASTER_BOOST:  settings.master_audio_boost   <= bridge_wr_data[1:0];
        OFS_ADPCM_BOOST:   settings.adpcm_audio_boost    <= bridge_wr_data[0];
        OFS_CD_BOOST:      settings.cd_audio_boost       <= bridge_wr_data[0];
        // unknown offsets and the reset trigger leave fields alone
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // core reset hold

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      hold_cnt <= '0;
    end else if (reset_wr) begin
      hold_cnt <= HOLD_W'(`PCE_RESET_HOLD);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // high for exactly PCE_RESET_HOLD cycles after the trigger
  assign core_reset = (hold_cnt != '0);

  ////////////////////////////////////////////////////////////
  // readback

  always_comb begin
    settings_rd_data = '0;
    case (offset)
      OFS_CORE_RESET:    settings_rd_data[0]   = core_reset;
      OFS_TURBO_TAP:     settings_rd_data[0]   = settings.turbo_tap_enable;
      OFS_BUTTON6:       settings_rd_data[0]   = settings.button6_enable;
      OFS_B1_TURBO:      settings_rd_data[1:0] = settings.button1_turbo_speed;
      OFS_B2_TURBO:      settings_rd_data[1:0] = settings.button2_turbo_speed;
      OFS_OVERSCAN:      settings_rd_data[0]   = settings.overscan_enable;
      OFS_EXTRA_SPRITES: settings_rd_data[0]   = settings.extra_sprites_enable;
      OFS_RAW_RGB:       settings_rd_data[0]   = settings.raw_rgb_enable;
      OFS_MASTER_BOOST:  settings_rd_data[1:0] = settings.master_audio_boost;
      OFS_ADPCM_BOOST:   settings_rd_data[0]   = settings.adpcm_audio_boost;
      OFS_CD_BOOST:      settings_rd_data[0]   = settings.cd_audio_boost;
      default: ;
    endcase
  end

  // the hold only starts from a host trigger
  assert property (@(posedge clk_74a) disable iff (reset)
    (!core_reset && !reset_wr) |=> !core_reset)
    else $error("core_reset rose without a reset trigger write");

endmodule

//--- rom_loader.sv
// ROM data loader
// buffers 32-bit big-endian bridge words and splits each one into
// two 16-bit memory writes, upper half first, with idle gaps
`timescale 1ns/1ps
`include "pce_params.svh"

module rom_loader
  import pce_core_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     reset,
  input  logic                     loader_wr,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_addr,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_wr_data,
  output mem_write_t               rom_write
);

  localparam int DEPTH = `PCE_LOADER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int GAP_W = $clog2(`PCE_LOADER_GAP + 1);

  typedef struct packed {
    logic [`PCE_MEM_ADDR_W-1:0] addr;
    logic [`PCE_BRIDGE_W-1:0]   data;
  } fifo_entry_t;

  typedef enum logic [2:0] {
    IDLE,
    WRITE_HI,
    GAP_HI,
    WRITE_LO,
    GAP_LO
  } state_t;

  fifo_entry_t        mem [DEPTH];
  fifo_entry_t        cur;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               fifo_full;
  logic               pop;
  state_t             state;
  logic [GAP_W-1:0]   gap_cnt;

  ////////////////////////////////////////////////////////////
  // word FIFO

  assign fifo_full = (count == CNT_W'(DEPTH));
  assign pop       = (state == IDLE) && (count != '0);

  // entry storage and the word being split
  always_ff @(posedge clk_74a) begin
    if (loader_wr) begin
      mem[wr_ptr] <= '{addr: bridge_addr[`PCE_MEM_ADDR_W-1:0], data: bridge_wr_data};
    end
    if (pop) begin
      cur <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (loader_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the count
      if (loader_wr && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !loader_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // half-word splitter

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      state   <= IDLE;
      gap_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (pop) begin
            state <= WRITE_HI;
          end
        end
        WRITE_HI: begin
          state   <= GAP_HI;
          gap_cnt <= GAP_W'(`PCE_LOADER_GAP - 1);
        end
        GAP_HI: begin
          if (gap_cnt == '0) begin
            state <= WRITE_LO;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        WRITE_LO: begin
          state   <= GAP_LO;
          gap_cnt <= GAP_W'(`PCE_LOADER_GAP - 1);
        end
        GAP_LO: begin
          if (gap_cnt == '0) begin
            state <= IDLE;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // big-endian, so the upper half goes to the lower address
  always_comb begin
    rom_write.en   = (state == WRITE_HI) || (state == WRITE_LO);
    rom_write.addr = (state == WRITE_LO) ? cur.addr + `PCE_MEM_ADDR_W'(2) : cur.addr;
    rom_write.data = (state == WRITE_LO) ? cur.data[15:0] : cur.data[31:16];
  end

  // host must respect the buffer depth
  assert property (@(posedge clk_74a) disable iff (reset)
    loader_wr |-> !fifo_full)
    else $error("loader push while FIFO full");

  // each pulse is followed by a gap
  assert property (@(posedge clk_74a) disable iff (reset)
    rom_write.en |=> !rom_write.en)
    else $error("rom_write.en held two cycles");

endmodule

//--- core_top.sv
// bridge-side top of the console core
// region decode, settings registers and ROM loader on clk_74a
`timescale 1ns/1ps
`include "pce_params.svh"

module core_top
  import pce_core_pkg::*;
(
  input  logic                     clk_74a,
  input  logic                     reset,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_addr,
  input  logic                     bridge_rd,
  input  logic                     bridge_wr,
  input  logic [`PCE_BRIDGE_W-1:0] bridge_wr_data,
  output logic [`PCE_BRIDGE_W-1:0] bridge_rd_data,
  output core_settings_t           settings,
  output logic                     core_reset,
  output mem_write_t               rom_write
);

  logic                     settings_wr;
  logic                     loader_wr;
  logic [`PCE_BRIDGE_W-1:0] settings_rd_data;

  bridge_region_decode u_decode (
    .bridge_addr      (bridge_addr),
    .bridge_wr        (bridge_wr),
    .settings_rd_data (settings_rd_data),
    .settings_wr      (settings_wr),
    .loader_wr        (loader_wr),
    .bridge_rd_data   (bridge_rd_data)
  );

  core_settings_regs u_settings (
    .clk_74a          (clk_74a),
    .reset            (reset),
    .settings_wr      (settings_wr),
    .bridge_addr      (bridge_addr),
    .bridge_wr_data   (bridge_wr_data),
    .settings         (settings),
    .core_reset       (core_reset),
    .settings_rd_data (settings_rd_data)
  );

  rom_loader u_loader (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .loader_wr      (loader_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .rom_write      (rom_write)
  );

  // bridge issues one access at a time
  assert property (@(posedge clk_74a) disable iff (reset)
    !(bridge_rd && bridge_wr))
    else $error("bridge read and write in the same cycle");

endmodule

//--- tb_core_top.sv
// testbench for the bridge-side core top
// drives bridge writes and reads, checks settings, reset hold and ROM loader
`timescale 1ns/1ps
`include "pce_params.svh"

module tb_core_top
  import pce_bridge_pkg::*;
  import pce_core_pkg::*;
;

  // about ten times the expected test length
  localparam int WATCHDOG_CYCLES = 4000;
  localparam logic [15:0] FIELD_OFS [10] = '{
    16'h0100, 16'h0104, 16'h0108, 16'h010C, 16'h0200,
    16'h0204, 16'h0208, 16'h0300, 16'h0304, 16'h0308
  };

  logic           clk_74a;
  logic           reset;
  logic [31:0]    bridge_addr;
  logic           bridge_rd;
  logic           bridge_wr;
  logic [31:0]    bridge_wr_data;
  logic [31:0]    bridge_rd_data;
  core_settings_t settings;
  logic           core_reset;
  mem_write_t     rom_write;

  core_settings_t exp_settings;
  mem_write_t     expect_q [$];
  mem_write_t     exp_write;
  logic [31:0]    rnd;
  logic [31:0]    loader_addr;
  logic           reset_trig;
  int             error_count;
  int             idle_cnt;
  int             hold_len;

  core_top DUT (
    .clk_74a        (clk_74a),
    .reset          (reset),
    .bridge_addr    (bridge_addr),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .core_reset     (core_reset),
    .rom_write      (rom_write)
  );

  always #4 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////
  // reference model of the settings block

  function automatic core_settings_t apply_write(core_settings_t s, logic [15:0] ofs,
                                                 logic [31:0] d);
    core_settings_t r;
    r = s;
    case (ofs)
      16'h0100: r.turbo_tap_enable     = d[0];
      16'h0104: r.button6_enable       = d[0];
      16'h0108: r.button1_turbo_speed  = d[1:0];
      16'h010C: r.button2_turbo_speed  = d[1:0];
      16'h0200: r.overscan_enable      = d[0];
      16'h0204: r.extra_sprites_enable = d[0];
      16'h0208: r.raw_rgb_enable       = d[0];
      16'h0300: r.master_audio_boost   = d[1:0];
      16'h0304: r.adpcm_audio_boost    = d[0];
      16'h0308: r.cd_audio_boost       = d[0];
      default: ;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] field_readback(core_settings_t s, logic [15:0] ofs);
    logic [31:0] r;
    r = '0;
    case (ofs)
      16'h0100: r[0]   = s.turbo_tap_enable;
      16'h0104: r[0]   = s.button6_enable;
      16'h0108: r[1:0] = s.button1_turbo_speed;
      16'h010C: r[1:0] = s.button2_turbo_speed;
      16'h0200: r[0]   = s.overscan_enable;
      16'h0204: r[0]   = s.extra_sprites_enable;
      16'h0208: r[0]   = s.raw_rgb_enable;
      16'h0300: r[1:0] = s.master_audio_boost;
      16'h0304: r[0]   = s.adpcm_audio_boost;
      16'h0308: r[0]   = s.cd_audio_boost;
      default: ;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus tasks

  task automatic report_failure(string msg);
    error_count++;
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic drive_write(logic [31:0] addr, logic [31:0] data);
    @(posedge clk_74a);
    #1;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
  endtask

  task automatic release_bus();
    @(posedge clk_74a);
    #1;
    bridge_wr = 1'b0;
    bridge_rd = 1'b0;
  endtask

  task automatic write_word(logic [31:0] addr, logic [31:0] data);
    drive_write(addr, data);
    release_bus();
  endtask

  task automatic read_expect(logic [31:0] addr, logic [31:0] expected, string msg);
    @(posedge clk_74a);
    #1;
    bridge_rd   = 1'b1;
    bridge_addr = addr;
    @(negedge clk_74a);
    assert (bridge_rd_data == expected)
      else report_failure($sformatf("%s: read %h at %h, expected %h",
                                    msg, bridge_rd_data, addr, expected));
    release_bus();
  endtask

  task automatic check_settings(string msg);
    @(negedge clk_74a);
    assert (settings == exp_settings)
      else report_failure($sformatf("%s: settings %h, expected %h",
                                    msg, settings, exp_settings));
  endtask

  task automatic check_all_readback();
    for (int i = 0; i < 10; i++) begin
      read_expect({16'h0000, FIELD_OFS[i]}, field_readback(exp_settings, FIELD_OFS[i]),
                  "settings readback");
    end
  endtask

  // big-endian split, upper half at the word address
  task automatic queue_loader_word(logic [31:0] addr, logic [31:0] data);
    expect_q.push_back('{en: 1'b1, addr: addr[`PCE_MEM_ADDR_W-1:0], data: data[31:16]});
    expect_q.push_back('{en: 1'b1, addr: addr[`PCE_MEM_ADDR_W-1:0] + `PCE_MEM_ADDR_W'(2),
                         data: data[15:0]});
  endtask

  task automatic wait_loader_drain();
    while (expect_q.size() != 0) begin
      @(negedge clk_74a);
    end
    // stray pulses would show up in this window
    repeat (2 * `PCE_LOADER_GAP) @(negedge clk_74a);
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and assertions

  assign reset_trig = bridge_wr && (bridge_addr == 32'h0000_0050);

  always @(negedge clk_74a) begin
    if (reset) begin
      idle_cnt = `PCE_LOADER_GAP;
    end else if (rom_write.en) begin
      assert (idle_cnt >= `PCE_LOADER_GAP)
        else report_failure($sformatf("rom write after only %0d idle cycles", idle_cnt));
      assert (expect_q.size() != 0)
        else report_failure("rom write with nothing expected");
      exp_write = expect_q.pop_front();
      assert (rom_write == exp_write)
        else report_failure($sformatf("rom write %h, expected %h", rom_write, exp_write));
      idle_cnt = 0;
    end else begin
      idle_cnt++;
    end
  end

  assert property (@(posedge clk_74a) $fell(reset) |->
    (settings == '0 && !core_reset && !rom_write.en))
    else report_failure("outputs not cleared by reset");

  assert property (@(posedge clk_74a) disable iff (reset)
    $rose(core_reset) |-> $past(reset_trig))
    else report_failure("core_reset rose without a trigger one cycle earlier");

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_74a);
    $display("watchdog fired after %0d cycles, test did not finish", WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "timeout");
  end

  initial begin
    clk_74a        = 1'b0;
    reset          = 1'b1;
    bridge_addr    = '0;
    bridge_rd      = 1'b0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    exp_settings   = '0;
    error_count    = 0;
    idle_cnt       = 0;
    hold_len       = 0;
    void'($urandom(32'h22449ff6));
    repeat (8) @(posedge clk_74a);
    #1;
    reset = 1'b0;
    check_settings("settings after reset");

    // each field with random data
    for (int i = 0; i < 10; i++) begin
      rnd = $urandom();
      write_word({16'h0000, FIELD_OFS[i]}, rnd);
      exp_settings = apply_write(exp_settings, FIELD_OFS[i], rnd);
      check_settings("settings after field write");
    end

    check_all_readback();
    read_expect(32'h0000_0400, 32'h0, "unknown offset");
    read_expect(32'h1000_0100, 32'h0, "loader region");
    read_expect(32'h2000_0100, 32'h0, "unmapped region");
    write_word(32'h0000_0400, $urandom());
    check_settings("write to unknown offset");
    write_word(32'h0000_0102, 32'hFFFF_FFFF);
    check_settings("write to misaligned offset");

    // core reset hold, readback taken mid-hold
    write_word(32'h0000_0050, 32'h1);
    fork
      begin
        @(negedge clk_74a);
        while (core_reset) begin
          hold_len++;
          @(negedge clk_74a);
        end
      end
      read_expect(32'h0000_0050, 32'h1, "core reset readback during hold");
    join
    assert (hold_len == `PCE_RESET_HOLD)
      else report_failure($sformatf("core_reset held %0d cycles, expected %0d",
                                    hold_len, `PCE_RESET_HOLD));
    read_expect(32'h0000_0050, 32'h0, "core reset readback after hold");
    check_settings("settings after core reset");

    // single loader word
    rnd         = $urandom();
    loader_addr = {4'h1, rnd[27:2], 2'b00};
    rnd         = $urandom();
    queue_loader_word(loader_addr, rnd);
    write_word(loader_addr, rnd);
    wait_loader_drain();

    // full FIFO depth back to back
    for (int i = 0; i < `PCE_LOADER_DEPTH; i++) begin
      rnd         = $urandom();
      loader_addr = {4'h1, rnd[27:2], 2'b00};
      rnd         = $urandom();
      queue_loader_word(loader_addr, rnd);
      drive_write(loader_addr, rnd);
    end
    release_bus();
    wait_loader_drain();
    check_all_readback();

    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
pce_bridge_pkg.sv
pce_core_pkg.sv
bridge_region_decode.sv
core_settings_regs.sv
rom_loader.sv
core_top.sv
tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_core_top \
  -o tb_core_top_sim || { echo "build failed"; exit 1; }

result=$(./obj_dir/tb_core_top_sim 2>&1)
echo "$result"

echo "$result" | grep -qx "No errors" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
